// File: Bender.yml
package:
  name: vaddr_gen

export_include_dirs:
  - common

sources:
  - common/vaddr_pkg.sv
  - src/req_fifo.sv
  - src/insn_ctrl.sv
  - stride_gen/stride_gen.sv
  - index_gen/index_gen.sv
  - src/req_issue.sv
  - src/vaddr_gen.sv
  - target: test
    files:
      - testbench/vaddr_gen_assert.sv
      - testbench/tb_vaddr_gen.sv

// File: common/vaddr_config.svh
/*
 * vector address generator configuration
 * widths and depths shared by the package and the RTL
 */

`ifndef VADDR_CONFIG_SVH
`define VADDR_CONFIG_SVH

// byte address width
`define VADDR_ADDR_WIDTH 32

// index operand word width
`define VADDR_ELEN 64

// element count width, vl up to 255
`define VADDR_VL_WIDTH 8

// unit-stride beat in bytes
`define VADDR_BEAT_BYTES 8

// queue toward the load/store units
`define VADDR_LSU_DEPTH 2

// buffer of computed indexed addresses
`define VADDR_IDX_DEPTH 2

`endif

// File: common/vaddr_pkg.sv
/*
 * vector address generator types
 * instruction, memory request and the element width helpers
 */

`include "vaddr_config.svh"

package vaddr_pkg;

  typedef logic [`VADDR_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`VADDR_VL_WIDTH-1:0]   vlen_t;
  typedef logic [`VADDR_ELEN-1:0]       elem_t;

  // log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    MODE_UNIT    = 2'd0,
    MODE_STRIDED = 2'd1,
    MODE_INDEXED = 2'd2
  } mem_mode_e;

  // one vector load or store
  typedef struct packed {
    mem_mode_e mode;
    logic      is_load;
    addr_t     base;
    // byte stride, strided mode only
    addr_t     stride;
    vlen_t     vl;
    // data element width
    vew_e      vew;
    // index element width, indexed mode only
    vew_e      eew_idx;
  } insn_t;

  // single-word memory request
  typedef struct packed {
    addr_t      addr;
    // log2 bytes
    logic [1:0] size;
    logic       is_load;
  } mem_req_t;

  // any low bit set below the element width
  function automatic logic is_misaligned(addr_t addr, vew_e ew);
    return |(addr & ((addr_t'(1) << ew) - addr_t'(1)));
  endfunction

endpackage

// File: index_gen/index_gen.sv
/*
 * index unpacker
 * splits index words into elements, adds each to the base,
 * buffers the aligned addresses and stops at the first misaligned one
 */

`timescale 1ns/1ps

`include "vaddr_config.svh"

module index_gen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vaddr_pkg::insn_t    insn_i,
  input  logic                start_i,
  input  vaddr_pkg::elem_t    idx_word_i,
  input  logic                idx_valid_i,
  output logic                idx_ready_o,
  output vaddr_pkg::mem_req_t cand_o,
  output logic                cand_valid_o,
  input  logic                take_i,
  output logic                done_o,
  output logic                error_o,
  output vaddr_pkg::vlen_t    error_vl_o
);

  localparam int unsigned PTR_W = $clog2(`VADDR_ELEN / 8);

  logic             active_q, err_q;
  logic [PTR_W-1:0] elm_ptr_q, last_ptr;
  vaddr_pkg::vlen_t remain_q, err_vl_q;
  vaddr_pkg::elem_t field;
  vaddr_pkg::addr_t idx_addr, head_addr;
  logic             extract, addr_bad, push;
  logic             last_field, last_elem;
  logic             buf_full, buf_empty;

  //////////////////////////////////////////////////////////////////////////
  // element extraction
  //////////////////////////////////////////////////////////////////////////

  // field at the element pointer, zero extended
  always_comb begin
    unique case (insn_i.eew_idx)
      vaddr_pkg::EW8: begin
        field    = vaddr_pkg::elem_t'(idx_word_i[elm_ptr_q*8 +: 8]);
        last_ptr = PTR_W'(7);
      end
      vaddr_pkg::EW16: begin
        field    = vaddr_pkg::elem_t'(idx_word_i[elm_ptr_q[1:0]*16 +: 16]);
        last_ptr = PTR_W'(3);
      end
      vaddr_pkg::EW32: begin
        field    = vaddr_pkg::elem_t'(idx_word_i[elm_ptr_q[0]*32 +: 32]);
        last_ptr = PTR_W'(1);
      end
      default: begin
        field    = idx_word_i;
        last_ptr = '0;
      end
    endcase
  end

  assign idx_addr = insn_i.base + field[`VADDR_ADDR_WIDTH-1:0];
  assign addr_bad = vaddr_pkg::is_misaligned(idx_addr, insn_i.vew);

  // one element per cycle while the buffer has room
  assign extract = active_q && !err_q && (remain_q != '0) && idx_valid_i && !buf_full;

  // faulting address never enters the buffer
  assign push       = extract && !addr_bad;
  assign last_field = (elm_ptr_q == last_ptr);
  assign last_elem  = (remain_q == vaddr_pkg::vlen_t'(1));

  // release the word after its last used field
  assign idx_ready_o = push && (last_field || last_elem);

  // buffer drained and nothing more to extract
  assign done_o = active_q && buf_empty && ((remain_q == '0) || err_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q  <= 1'b0;
      err_q     <= 1'b0;
      elm_ptr_q <= '0;
      remain_q  <= '0;
      err_vl_q  <= '0;
    end else if (start_i) begin
      active_q  <= 1'b1;
      err_q     <= 1'b0;
      elm_ptr_q <= '0;
      remain_q  <= insn_i.vl;
    end else begin
      if (done_o) begin
        active_q <= 1'b0;
      end
      if (extract && addr_bad) begin
        err_q    <= 1'b1;
        // elements before the faulting one
        err_vl_q <= insn_i.vl - remain_q;
      end
      if (push) begin
        remain_q  <= remain_q - 1'b1;
        elm_ptr_q <= idx_ready_o ? '0 : elm_ptr_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // address buffer
  //////////////////////////////////////////////////////////////////////////

  req_fifo #(
    .T    (vaddr_pkg::addr_t),
    .DEPTH(`VADDR_IDX_DEPTH)
  ) i_idx_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (idx_addr),
    .push_i (push),
    .data_o (head_addr),
    .pop_i  (take_i),
    .full_o (buf_full),
    .empty_o(buf_empty)
  );

  // data element width sets the request size
  assign cand_o       = '{addr: head_addr, size: insn_i.vew, is_load: insn_i.is_load};
  assign cand_valid_o = !buf_empty;

  assign error_o    = err_q;
  assign error_vl_o = err_vl_q;

endmodule

// File: project.f
+incdir+common
common/vaddr_pkg.sv
src/req_fifo.sv
src/insn_ctrl.sv
stride_gen/stride_gen.sv
index_gen/index_gen.sv
src/req_issue.sv
src/vaddr_gen.sv
testbench/vaddr_gen_assert.sv
testbench/tb_vaddr_gen.sv

// File: src/insn_ctrl.sv
/*
 * instruction controller
 * accepts one load or store, rejects a misaligned base,
 * starts a generator and reports the registered acknowledge
 */

`timescale 1ns/1ps

module insn_ctrl (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  vaddr_pkg::insn_t  insn_i,
  input  logic              insn_valid_i,
  output vaddr_pkg::insn_t  insn_o,
  output logic              stride_start_o,
  output logic              index_start_o,
  input  logic              stride_done_i,
  input  logic              index_done_i,
  input  logic              index_error_i,
  input  vaddr_pkg::vlen_t  index_error_vl_i,
  output logic              ack_o,
  output logic              error_o,
  output vaddr_pkg::vlen_t  error_vl_o
);

  // ACK only serves an instruction rejected at accept
  typedef enum logic [1:0] {IDLE, BUSY_STRIDE, BUSY_INDEX, ACK} state_e;

  state_e           state_q, state_d;
  vaddr_pkg::insn_t insn_q;
  logic             accept;
  logic             ack_d, error_d;
  vaddr_pkg::vlen_t error_vl_d;
  logic             stride_start_d, index_start_d;

  // busy unit ignores new instructions
  assign accept = (state_q == IDLE) && insn_valid_i;
  assign insn_o = insn_q;

  //////////////////////////////////////////////////////////////////////////
  // next state and result
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    ack_d          = 1'b0;
    error_d        = 1'b0;
    error_vl_d     = '0;
    stride_start_d = 1'b0;
    index_start_d  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (accept) begin
          if (insn_i.mode == vaddr_pkg::MODE_INDEXED) begin
            // index addresses are checked one by one later
            state_d       = BUSY_INDEX;
            index_start_d = 1'b1;
          end else if (vaddr_pkg::is_misaligned(insn_i.base, insn_i.vew)) begin
            state_d = ACK;
          end else begin
            state_d        = BUSY_STRIDE;
            stride_start_d = 1'b1;
          end
        end
      end
      BUSY_STRIDE: begin
        if (stride_done_i) begin
          state_d    = IDLE;
          ack_d      = 1'b1;
          error_vl_d = insn_q.vl;
        end
      end
      BUSY_INDEX: begin
        if (index_done_i) begin
          state_d    = IDLE;
          ack_d      = 1'b1;
          error_d    = index_error_i;
          // elements done before the fault
          error_vl_d = index_error_i ? index_error_vl_i : insn_q.vl;
        end
      end
      ACK: begin
        // misaligned base, nothing was issued
        state_d = IDLE;
        ack_d   = 1'b1;
        error_d = 1'b1;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      ack_o          <= 1'b0;
      error_o        <= 1'b0;
      error_vl_o     <= '0;
      stride_start_o <= 1'b0;
      index_start_o  <= 1'b0;
    end else begin
      state_q        <= state_d;
      ack_o          <= ack_d;
      error_o        <= error_d;
      error_vl_o     <= error_vl_d;
      stride_start_o <= stride_start_d;
      index_start_o  <= index_start_d;
    end
  end

  // held for the whole run
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= insn_i;
    end
  end

endmodule

// File: src/req_fifo.sv
/*
 * small ring buffer FIFO
 * payload type and depth set per instance
 */

`timescale 1ns/1ps

module req_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  T     data_i,
  input  logic push_i,
  output T     data_o,
  input  logic pop_i,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   cnt_q;
  logic             do_push, do_pop;

  // wrap at DEPTH, not only at a power of two
  function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full_o  = (cnt_q == (PTR_W + 1)'(DEPTH));
  assign empty_o = (cnt_q == '0);

  // overflow and underflow are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // head is always visible
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // simultaneous push and pop keep the count
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

// File: src/req_issue.sv
/*
 * request issuer
 * drives the memory port from the active generator and
 * queues every granted request toward the load/store units
 */

`timescale 1ns/1ps

`include "vaddr_config.svh"

module req_issue (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vaddr_pkg::mem_req_t stride_cand_i,
  input  logic                stride_valid_i,
  output logic                stride_take_o,
  input  vaddr_pkg::mem_req_t index_cand_i,
  input  logic                index_valid_i,
  output logic                index_take_o,
  output vaddr_pkg::mem_req_t mem_req_o,
  output logic                mem_req_valid_o,
  input  logic                mem_gnt_i,
  output vaddr_pkg::mem_req_t lsu_req_o,
  output logic                lsu_req_valid_o,
  input  logic                lsu_ready_i
);

  logic lsu_full, lsu_empty;
  logic granted;

  // only one generator runs at a time, stride first anyway
  assign mem_req_o = stride_valid_i ? stride_cand_i : index_cand_i;

  // no offer without a free queue slot
  assign mem_req_valid_o = (stride_valid_i || index_valid_i) && !lsu_full;
  assign granted         = mem_req_valid_o && mem_gnt_i;

  // take goes back to the source of the granted request
  assign stride_take_o = granted && stride_valid_i;
  assign index_take_o  = granted && !stride_valid_i;

  //////////////////////////////////////////////////////////////////////////
  // queue toward the load/store units
  //////////////////////////////////////////////////////////////////////////

  req_fifo #(
    .T    (vaddr_pkg::mem_req_t),
    .DEPTH(`VADDR_LSU_DEPTH)
  ) i_lsu_fifo (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .data_i (mem_req_o),
    .push_i (granted),
    .data_o (lsu_req_o),
    .pop_i  (lsu_ready_i && lsu_req_valid_o),
    .full_o (lsu_full),
    .empty_o(lsu_empty)
  );

  assign lsu_req_valid_o = !lsu_empty;

endmodule

// File: src/vaddr_gen.sv
/*
 * vector memory address generator, top level
 * turns unit-stride, strided and indexed loads and stores
 * into single-word memory requests
 */

`timescale 1ns/1ps

module vaddr_gen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  vaddr_pkg::insn_t    insn_i,
  input  logic                insn_valid_i,
  input  vaddr_pkg::elem_t    idx_word_i,
  input  logic                idx_valid_i,
  output logic                idx_ready_o,
  output vaddr_pkg::mem_req_t mem_req_o,
  output logic                mem_req_valid_o,
  input  logic                mem_gnt_i,
  output vaddr_pkg::mem_req_t lsu_req_o,
  output logic                lsu_req_valid_o,
  input  logic                lsu_ready_i,
  output logic                ack_o,
  output logic                error_o,
  output vaddr_pkg::vlen_t    error_vl_o
);

  // stored instruction and start pulses
  vaddr_pkg::insn_t    insn;
  logic                stride_start, index_start;
  // candidates toward the issuer
  vaddr_pkg::mem_req_t stride_cand, index_cand;
  logic                stride_valid, index_valid;
  logic                stride_take, index_take;
  // completion back to the controller
  logic                stride_done, index_done;
  logic                index_error;
  vaddr_pkg::vlen_t    index_error_vl;

  insn_ctrl i_insn_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_i          (insn_i),
    .insn_valid_i    (insn_valid_i),
    .insn_o          (insn),
    .stride_start_o  (stride_start),
    .index_start_o   (index_start),
    .stride_done_i   (stride_done),
    .index_done_i    (index_done),
    .index_error_i   (index_error),
    .index_error_vl_i(index_error_vl),
    .ack_o           (ack_o),
    .error_o         (error_o),
    .error_vl_o      (error_vl_o)
  );

  stride_gen i_stride_gen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .insn_i      (insn),
    .start_i     (stride_start),
    .cand_o      (stride_cand),
    .cand_valid_o(stride_valid),
    .take_i      (stride_take),
    .done_o      (stride_done)
  );

  index_gen i_index_gen (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .insn_i      (insn),
    .start_i     (index_start),
    .idx_word_i  (idx_word_i),
    .idx_valid_i (idx_valid_i),
    .idx_ready_o (idx_ready_o),
    .cand_o      (index_cand),
    .cand_valid_o(index_valid),
    .take_i      (index_take),
    .done_o      (index_done),
    .error_o     (index_error),
    .error_vl_o  (index_error_vl)
  );

  req_issue i_req_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .stride_cand_i  (stride_cand),
    .stride_valid_i (stride_valid),
    .stride_take_o  (stride_take),
    .index_cand_i   (index_cand),
    .index_valid_i  (index_valid),
    .index_take_o   (index_take),
    .mem_req_o      (mem_req_o),
    .mem_req_valid_o(mem_req_valid_o),
    .mem_gnt_i      (mem_gnt_i),
    .lsu_req_o      (lsu_req_o),
    .lsu_req_valid_o(lsu_req_valid_o),
    .lsu_ready_i    (lsu_ready_i)
  );

endmodule

// File: stride_gen/stride_gen.sv
/*
 * stride walker
 * unit-stride beats or strided elements, one candidate at a time
 */

`timescale 1ns/1ps

`include "vaddr_config.svh"

module stride_gen (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vaddr_pkg::insn_t      insn_i,
  input  logic                  start_i,
  output vaddr_pkg::mem_req_t   cand_o,
  output logic                  cand_valid_o,
  input  logic                  take_i,
  output logic                  done_o
);

  localparam int unsigned BEAT_SHIFT = $clog2(`VADDR_BEAT_BYTES);
  localparam int unsigned BYTES_W    = `VADDR_VL_WIDTH + BEAT_SHIFT;

  logic [BYTES_W-1:0] vl_bytes, vl_beats;
  logic               is_unit;
  vaddr_pkg::vlen_t   start_cnt, cnt_q;
  vaddr_pkg::addr_t   addr_q, step_q;
  logic [1:0]         size_q;
  logic               is_load_q;
  logic               empty_q;

  assign is_unit = (insn_i.mode == vaddr_pkg::MODE_UNIT);

  // whole beats covering vl elements, rounded up
  assign vl_bytes  = BYTES_W'(insn_i.vl) << insn_i.vew;
  assign vl_beats  = (vl_bytes + BYTES_W'(`VADDR_BEAT_BYTES - 1)) >> BEAT_SHIFT;
  assign start_cnt = is_unit ? vl_beats[`VADDR_VL_WIDTH-1:0] : insn_i.vl;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q   <= '0;
      empty_q <= 1'b0;
    end else begin
      // vl of zero still needs a done
      empty_q <= start_i && (start_cnt == '0);
      if (start_i) begin
        cnt_q <= start_cnt;
      end else if (take_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // current address, step and request shape
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      addr_q    <= insn_i.base;
      step_q    <= is_unit ? vaddr_pkg::addr_t'(`VADDR_BEAT_BYTES) : insn_i.stride;
      size_q    <= is_unit ? 2'(BEAT_SHIFT) : insn_i.vew;
      is_load_q <= insn_i.is_load;
    end else if (take_i) begin
      addr_q <= addr_q + step_q;
    end
  end

  assign cand_o = '{addr: addr_q, size: size_q, is_load: is_load_q};

  // stays up until the last take
  assign cand_valid_o = (cnt_q != '0);
  assign done_o       = (take_i && (cnt_q == vaddr_pkg::vlen_t'(1))) || empty_q;

endmodule

// File: testbench/tb_vaddr_gen.sv
/*
 * testbench for the vector address generator
 * directed unit-stride, strided and indexed runs under random grants
 * and LSU back-pressure, checked against a request model
 */

`timescale 1ns/1ps

module tb_vaddr_gen;

  // request counts of the six tests set the cycle limit
  localparam int unsigned REQ_TOTAL   = 3 + 6 + 16 + 2 + 0 + 4;
  localparam int unsigned CYCLE_LIMIT = REQ_TOTAL * 20 + 200;

  logic                clk;
  logic                rst_n;
  vaddr_pkg::insn_t    insn;
  logic                insn_valid;
  vaddr_pkg::elem_t    idx_word;
  logic                idx_valid, idx_ready;
  vaddr_pkg::mem_req_t mem_req, lsu_req;
  logic                mem_req_valid, mem_gnt;
  logic                lsu_req_valid, lsu_ready;
  logic                ack, error;
  vaddr_pkg::vlen_t    error_vl;

  // stimulus control and bookkeeping
  logic [31:0]         lfsr_q;
  logic                gnt_random, rdy_low;
  int unsigned         cycle_cnt, offer_cnt, idx_pulses;
  vaddr_pkg::elem_t    idx_words[$];
  vaddr_pkg::mem_req_t granted_q[$];
  vaddr_pkg::mem_req_t lsu_model_q[$];
  vaddr_pkg::mem_req_t exp_q[$];

  vaddr_gen i_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .insn_i         (insn),
    .insn_valid_i   (insn_valid),
    .idx_word_i     (idx_word),
    .idx_valid_i    (idx_valid),
    .idx_ready_o    (idx_ready),
    .mem_req_o      (mem_req),
    .mem_req_valid_o(mem_req_valid),
    .mem_gnt_i      (mem_gnt),
    .lsu_req_o      (lsu_req),
    .lsu_req_valid_o(lsu_req_valid),
    .lsu_ready_i    (lsu_ready),
    .ack_o          (ack),
    .error_o        (error),
    .error_vl_o     (error_vl)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic vaddr_pkg::insn_t make_insn(vaddr_pkg::mem_mode_e mode, logic is_load,
      vaddr_pkg::addr_t base, vaddr_pkg::addr_t stride, vaddr_pkg::vlen_t vl,
      vaddr_pkg::vew_e vew, vaddr_pkg::vew_e eew_idx);
    vaddr_pkg::insn_t r;
    r.mode    = mode;
    r.is_load = is_load;
    r.base    = base;
    r.stride  = stride;
    r.vl      = vl;
    r.vew     = vew;
    r.eew_idx = eew_idx;
    return r;
  endfunction

  function automatic vaddr_pkg::mem_req_t make_req(vaddr_pkg::addr_t addr, logic [1:0] size,
      logic is_load);
    vaddr_pkg::mem_req_t r;
    r.addr    = addr;
    r.size    = size;
    r.is_load = is_load;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_on_error(string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_req(vaddr_pkg::mem_req_t got, vaddr_pkg::mem_req_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Error: mem_req_o got %h expected %h", got, exp));
    end
  endtask

  task automatic check_lsu(vaddr_pkg::mem_req_t got, vaddr_pkg::mem_req_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("Error: lsu_req_o got %h expected %h", got, exp));
    end
  endtask

  task automatic check_ack(logic err_got, vaddr_pkg::vlen_t vl_got, logic err_exp,
      vaddr_pkg::vlen_t vl_exp);
    if (err_got !== err_exp) begin
      stop_on_error($sformatf("Error: error_o got %h expected %h", err_got, err_exp));
    end else if (vl_got !== vl_exp) begin
      stop_on_error($sformatf("Error: error_vl_o got %h expected %h", vl_got, vl_exp));
    end
  endtask

  task automatic check_count(string name, int unsigned got, int unsigned exp);
    if (got != exp) begin
      stop_on_error($sformatf("Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // drivers and monitor
  ////////////////////////////////////////////////////////////////////////////

  // one LFSR step per random bit
  always @(posedge clk) begin
    if (gnt_random) begin
      lfsr_q = lfsr_next(lfsr_q);
      mem_gnt <= lfsr_q[0];
    end else begin
      mem_gnt <= 1'b1;
    end
    if (rdy_low) begin
      lsu_ready <= 1'b0;
    end else begin
      lfsr_q = lfsr_next(lfsr_q);
      lsu_ready <= lfsr_q[0];
    end
  end

  // head word stays on the port until idx_ready
  always @(posedge clk) begin
    if (rst_n && idx_ready) begin
      idx_pulses++;
      if (idx_words.size() != 0) begin
        void'(idx_words.pop_front());
      end
    end
    if (idx_words.size() != 0) begin
      idx_valid <= 1'b1;
      idx_word  <= idx_words[0];
    end else begin
      idx_valid <= 1'b0;
    end
  end

  // grants feed the model and pops are checked against it in order
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      stop_on_error($sformatf("timeout, the run went past %0d cycles", CYCLE_LIMIT));
    end else if (rst_n) begin
      if (mem_req_valid) begin
        offer_cnt++;
      end
      if (lsu_req_valid && lsu_ready) begin
        if (lsu_model_q.size() == 0) begin
          stop_on_error("the LSU queue sent a request that was never granted");
        end else begin
          check_lsu(lsu_req, lsu_model_q.pop_front());
        end
      end
      if (mem_req_valid && mem_gnt) begin
        granted_q.push_back(mem_req);
        lsu_model_q.push_back(mem_req);
      end
      if (i_dut.i_assert.fail_cnt != 0) begin
        stop_on_error("a bound assertion on the DUT ports failed");
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // sequencing
  ////////////////////////////////////////////////////////////////////////////

  task automatic start_insn(vaddr_pkg::insn_t insn_v);
    granted_q.delete();
    offer_cnt  = 0;
    idx_pulses = 0;
    insn       <= insn_v;
    insn_valid <= 1'b1;
    @(posedge clk);
    insn_valid <= 1'b0;
  endtask

  // cycles counted from the accepting edge
  task automatic finish_insn(logic err_exp, vaddr_pkg::vlen_t vl_exp,
      output int unsigned cycles);
    logic             err_got;
    vaddr_pkg::vlen_t vl_got;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!ack);
    err_got = error;
    vl_got  = error_vl;
    check_ack(err_got, vl_got, err_exp, vl_exp);
    check_count("granted request count", granted_q.size(), exp_q.size());
    foreach (exp_q[i]) begin
      check_req(granted_q[i], exp_q[i]);
    end
    while (lsu_model_q.size() != 0 || lsu_req_valid) begin
      @(posedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_unit_load();
    vaddr_pkg::insn_t insn_v;
    int unsigned      beats;
    int unsigned      cycles;
    insn_v = make_insn(vaddr_pkg::MODE_UNIT, 1'b1, 32'h0000_1004, '0, 8'd5,
                       vaddr_pkg::EW32, vaddr_pkg::EW8);
    // 20 bytes of data take three 8-byte beats
    beats = 3;
    exp_q.delete();
    for (int i = 0; i < beats; i++) begin
      exp_q.push_back(make_req(insn_v.base + 8 * i, 2'd3, 1'b1));
    end
    start_insn(insn_v);
    finish_insn(1'b0, 8'd5, cycles);
  endtask

  task automatic test_strided_store();
    vaddr_pkg::insn_t insn_v;
    int unsigned      cycles;
    insn_v = make_insn(vaddr_pkg::MODE_STRIDED, 1'b0, 32'h0000_3002, 32'h0000_0016, 8'd6,
                       vaddr_pkg::EW16, vaddr_pkg::EW8);
    exp_q.delete();
    for (int i = 0; i < 6; i++) begin
      exp_q.push_back(make_req(insn_v.base + insn_v.stride * i, 2'd1, 1'b0));
    end
    start_insn(insn_v);
    finish_insn(1'b0, 8'd6, cycles);
  endtask

  task automatic test_indexed_load();
    vaddr_pkg::insn_t insn_v;
    vaddr_pkg::elem_t words[2];
    int unsigned      cycles;
    words[0] = 64'h3c2d_1e0f_f0e1_d2c3;
    words[1] = 64'h0011_2233_4455_6677;
    insn_v = make_insn(vaddr_pkg::MODE_INDEXED, 1'b1, 32'h0000_2000, '0, 8'd16,
                       vaddr_pkg::EW8, vaddr_pkg::EW8);
    exp_q.delete();
    // zero-extended byte offsets with the low byte first
    for (int w = 0; w < 2; w++) begin
      for (int b = 0; b < 8; b++) begin
        exp_q.push_back(make_req(insn_v.base + {24'h0, words[w][b*8 +: 8]}, 2'd0, 1'b1));
      end
    end
    idx_words.push_back(words[0]);
    idx_words.push_back(words[1]);
    start_insn(insn_v);
    finish_insn(1'b0, 8'd16, cycles);
    check_count("idx_ready_o pulse count", idx_pulses, 2);
  endtask

  task automatic test_indexed_fault();
    vaddr_pkg::insn_t insn_v;
    int unsigned      cycles;
    // third offset of 0 4 5 8 breaks 4-byte alignment
    insn_v = make_insn(vaddr_pkg::MODE_INDEXED, 1'b1, 32'h0000_6000, '0, 8'd4,
                       vaddr_pkg::EW32, vaddr_pkg::EW8);
    exp_q.delete();
    exp_q.push_back(make_req(32'h0000_6000, 2'd2, 1'b1));
    exp_q.push_back(make_req(32'h0000_6004, 2'd2, 1'b1));
    idx_words.push_back(64'h0000_0000_0805_0400);
    start_insn(insn_v);
    finish_insn(1'b1, 8'd2, cycles);
    // faulting word is never released
    idx_words.delete();
  endtask

  task automatic test_misaligned_base();
    vaddr_pkg::insn_t insn_v;
    int unsigned      cycles;
    insn_v = make_insn(vaddr_pkg::MODE_STRIDED, 1'b1, 32'h0000_4001, 32'h0000_0004, 8'd4,
                       vaddr_pkg::EW32, vaddr_pkg::EW8);
    exp_q.delete();
    start_insn(insn_v);
    finish_insn(1'b1, 8'd0, cycles);
    check_count("ack_o latency in cycles", cycles, 2);
    check_count("mem_req_valid_o cycle count", offer_cnt, 0);
  endtask

  task automatic test_lsu_backpressure();
    vaddr_pkg::insn_t insn_v;
    int unsigned      cycles;
    gnt_random = 1'b0;
    rdy_low    = 1'b1;
    repeat (2) @(posedge clk);
    insn_v = make_insn(vaddr_pkg::MODE_UNIT, 1'b1, 32'h0000_5000, '0, 8'd4,
                       vaddr_pkg::EW64, vaddr_pkg::EW8);
    exp_q.delete();
    for (int i = 0; i < 4; i++) begin
      exp_q.push_back(make_req(insn_v.base + 8 * i, 2'd3, 1'b1));
    end
    start_insn(insn_v);
    while (granted_q.size() < 2) begin
      @(posedge clk);
    end
    // no further offer while the queue is full
    repeat (3) begin
      @(posedge clk);
      if (mem_req_valid) begin
        stop_on_error("mem_req_valid_o stayed high while the LSU queue was full");
      end
    end
    gnt_random = 1'b1;
    rdy_low    = 1'b0;
    finish_insn(1'b0, 8'd4, cycles);
  endtask

  initial begin
    rst_n      = 1'b0;
    insn       = '0;
    insn_valid = 1'b0;
    idx_word   = '0;
    idx_valid  = 1'b0;
    mem_gnt    = 1'b0;
    lsu_ready  = 1'b0;
    lfsr_q     = 32'h23cc_01f7;
    gnt_random = 1'b1;
    rdy_low    = 1'b0;
    cycle_cnt  = 0;
    offer_cnt  = 0;
    idx_pulses = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    test_unit_load();
    test_strided_store();
    test_indexed_load();
    test_indexed_fault();
    test_misaligned_base();
    test_lsu_backpressure();

    if (i_dut.i_assert.fail_cnt == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_on_error("a bound assertion on the DUT ports failed");
    end
  end

endmodule

// File: testbench/vaddr_gen_assert.sv
/*
 * concurrent checks on the address generator ports
 * bound into every vaddr_gen instance
 */

`timescale 1ns/1ps

module vaddr_gen_assert (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                ack_i,
  input logic                error_i,
  input vaddr_pkg::mem_req_t mem_req_i,
  input logic                mem_req_valid_i,
  input logic                mem_gnt_i,
  input logic                lsu_req_valid_i
);

  // failures so far, polled by the testbench
  int unsigned fail_cnt = 0;

  // ack is a single-cycle strobe
  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni) ack_i |=> !ack_i)
    else begin
      fail_cnt++;
      $error("ack_o held for more than one cycle");
    end

  // offered request holds until granted
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_valid_i && !mem_gnt_i) |=> (mem_req_valid_i && $stable(mem_req_i)))
    else begin
      fail_cnt++;
      $error("mem_req_o changed or was withdrawn before its grant");
    end

  // error only qualifies an ack
  err_with_ack: assert property (@(posedge clk_i) disable iff (!rst_ni) error_i |-> ack_i)
    else begin
      fail_cnt++;
      $error("error_o high without ack_o");
    end

  // queue comes out of reset empty
  lsu_after_rst: assert property (@(posedge clk_i) $rose(rst_ni) |-> !lsu_req_valid_i)
    else begin
      fail_cnt++;
      $error("lsu_req_valid_o high right after reset");
    end

endmodule

bind vaddr_gen vaddr_gen_assert i_assert (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .ack_i          (ack_o),
  .error_i        (error_o),
  .mem_req_i      (mem_req_o),
  .mem_req_valid_i(mem_req_valid_o),
  .mem_gnt_i      (mem_gnt_i),
  .lsu_req_valid_i(lsu_req_valid_o)
);
